// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W   8            // Register and data bus width
`define CPU_ADDR_W   8            // Both bus address widths
`define CPU_INSTR_W  16           // Instruction word
`define CPU_REG_AW   3            // Register index width
`define CPU_REG_N    8            // Number of registers

// Register format, bits 11:6 under a zero prefix
`define OP_NOP  6'b000000
`define OP_ADD  6'b000001
`define OP_AND  6'b000010
`define OP_SUB  6'b000011
`define OP_OR   6'b000100
`define OP_XOR  6'b000101
`define OP_MOV  6'b000110
`define OP_NOT  6'b001000
`define OP_SAR  6'b001001
`define OP_SLR  6'b001010
`define OP_SLL  6'b001100
`define OP_INC  6'b001111
`define OP_DEC  6'b010000
`define OP_CMP  6'b010100

// Immediate format, bits 15:11
`define OP_JE   5'b10000
`define OP_JB   5'b10001
`define OP_JA   5'b10010
`define OP_JL   5'b10011
`define OP_JG   5'b10100
`define OP_JMP  5'b10101
`define OP_LI   5'b11000
`define OP_LM   5'b11001
`define OP_SM   5'b11010

`endif

// ==== cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    // One fetched word, read as either format
    typedef union packed {
        struct packed {
            logic [3:0]             prefix;   // All zero for this format
            logic [5:0]             op;
            logic [`CPU_REG_AW-1:0] rd;
            logic [`CPU_REG_AW-1:0] rs;       // Also the shift amount
        } r_form;
        struct packed {
            logic [4:0]             op;
            logic [`CPU_REG_AW-1:0] rd;
            logic [`CPU_DATA_W-1:0] imm;      // Value, data address or jump target
        } i_form;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_NOP,                              // Result is a, flags pass through
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_MOV,
        ALU_SAR,
        ALU_SLR,
        ALU_SLL,
        ALU_INC,
        ALU_DEC
    } alu_op_t;

    typedef struct packed {
        logic zf;
        logic sf;
        logic cf;
        logic of;
    } flags_t;

    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        DATA
    } cpu_state_t;

endpackage

// ==== reg_file_if.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

interface reg_file_if;
    logic [`CPU_REG_AW-1:0] rd_idx1;
    logic [`CPU_DATA_W-1:0] rd_data1;
    logic [`CPU_REG_AW-1:0] rd_idx2;
    logic [`CPU_DATA_W-1:0] rd_data2;
    logic [`CPU_REG_AW-1:0] wr_idx;
    logic [`CPU_DATA_W-1:0] wr_data;
    logic                   wr_en;       // Write on the rising edge

    modport ctrl (
        output rd_idx1, rd_idx2, wr_idx, wr_data, wr_en,
        input  rd_data1, rd_data2
    );

    modport bank (
        input  rd_idx1, rd_idx2, wr_idx, wr_data, wr_en,
        output rd_data1, rd_data2
    );
endinterface

// ==== register_bank.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module register_bank (
    input  logic     clk,
    input  logic     reset,
    reg_file_if.bank rf
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];

    // Two asynchronous read ports
    assign rf.rd_data1 = regs[rf.rd_idx1];
    assign rf.rd_data2 = regs[rf.rd_idx2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_N; i++) begin
                regs[i] <= '0;                    // Architectural state starts at zero
            end
        end else if (rf.wr_en) begin
            regs[rf.wr_idx] <= rf.wr_data;
        end
    end

    // The controller must never enable a write to an unknown register
    a_wr_idx_known: assert property (
        @(posedge clk) disable iff (reset)
        rf.wr_en |-> !$isunknown(rf.wr_idx)
    ) else $error("register_bank: write enabled with unknown index");

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t                op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  flags_t                 flags_in,
    output logic [`CPU_DATA_W-1:0] result,
    output flags_t                 flags_out
);

    logic [`CPU_DATA_W:0]   sum;         // Carry in the top bit
    logic [`CPU_DATA_W:0]   diff;        // Borrow in the top bit
    logic [`CPU_DATA_W:0]   shl;         // Last bit out on top
    logic [`CPU_DATA_W:0]   shr;         // Last bit out at bit 0
    logic [`CPU_DATA_W:0]   sar;
    logic [`CPU_REG_AW-1:0] amt;
    logic                   cf;
    logic                   of;
    logic                   upd;

    assign amt  = b[`CPU_REG_AW-1:0];
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // Extra guard bit catches the last bit shifted out, zero for amount 0
    assign shl = {1'b0, a} << amt;
    assign shr = {a, 1'b0} >> amt;
    assign sar = $signed({a, 1'b0}) >>> amt;

    always_comb begin
        result = a;
        cf     = 1'b0;
        of     = 1'b0;
        upd    = 1'b1;
        case (op)
            ALU_ADD: begin
                result = sum[`CPU_DATA_W-1:0];
                cf     = sum[`CPU_DATA_W];
                of     = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
                         (result[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
            end
            ALU_SUB: begin                            // Also CMP
                result = diff[`CPU_DATA_W-1:0];
                cf     = diff[`CPU_DATA_W];
                of     = (a[`CPU_DATA_W-1] != b[`CPU_DATA_W-1]) &&
                         (result[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_NOT: result = ~a;
            ALU_MOV: result = b;
            ALU_SAR: begin
                result = sar[`CPU_DATA_W:1];
                cf     = sar[0];
            end
            ALU_SLR: begin
                result = shr[`CPU_DATA_W:1];
                cf     = shr[0];
            end
            ALU_SLL: begin
                result = shl[`CPU_DATA_W-1:0];
                cf     = shl[`CPU_DATA_W];
            end
            ALU_INC: begin
                result = a + 1'b1;
                cf     = (result == '0);              // Wrapped past 0xFF
                of     = (result == {1'b1, {(`CPU_DATA_W-1){1'b0}}});
            end
            ALU_DEC: begin
                result = a - 1'b1;
                cf     = (a == '0);
                of     = (result == {1'b0, {(`CPU_DATA_W-1){1'b1}}});
            end
            default: upd = 1'b0;                      // NOP keeps the flags
        endcase

        if (upd) begin
            flags_out.zf = (result == '0);
            flags_out.sf = result[`CPU_DATA_W-1];
            flags_out.cf = cf;
            flags_out.of = of;
        end else begin
            flags_out = flags_in;
        end
    end

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_control import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    reg_file_if.ctrl                rf,
    output alu_op_t                 alu_op,
    output logic [`CPU_DATA_W-1:0]  alu_a,
    output logic [`CPU_DATA_W-1:0]  alu_b,
    input  logic [`CPU_DATA_W-1:0]  alu_result,
    input  flags_t                  alu_flags,
    output flags_t                  flags,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [`CPU_ADDR_W-1:0]  ibus_adr,
    input  logic [`CPU_INSTR_W-1:0] ibus_rdata,
    input  logic                    ibus_ack,
    output logic                    dbus_cyc,
    output logic                    dbus_stb,
    output logic                    dbus_we,
    output logic [`CPU_ADDR_W-1:0]  dbus_adr,
    output logic [`CPU_DATA_W-1:0]  dbus_wdata,
    input  logic [`CPU_DATA_W-1:0]  dbus_rdata,
    input  logic                    dbus_ack
);

    cpu_state_t             state;
    instr_t                 ir;          // Current instruction
    logic [`CPU_ADDR_W-1:0] pc;
    logic                   ibus_req;
    logic                   dbus_req;
    logic                   dbus_wr;
    logic                   is_r;
    logic                   is_shift;
    logic                   r_write;     // R-form result goes to rd
    logic                   is_li;
    logic                   is_lm;
    logic                   is_sm;
    logic                   jump_taken;

    assign is_r  = (ir.r_form.prefix == 4'b0000);
    assign is_li = (ir.i_form.op == `OP_LI);
    assign is_lm = (ir.i_form.op == `OP_LM);
    assign is_sm = (ir.i_form.op == `OP_SM);

    always_comb begin
        alu_op = ALU_NOP;                // Unlisted opcodes fall through as NOP
        if (is_r) begin
            case (ir.r_form.op)
                `OP_ADD: alu_op = ALU_ADD;
                `OP_SUB: alu_op = ALU_SUB;
                `OP_CMP: alu_op = ALU_SUB;
                `OP_AND: alu_op = ALU_AND;
                `OP_OR:  alu_op = ALU_OR;
                `OP_XOR: alu_op = ALU_XOR;
                `OP_NOT: alu_op = ALU_NOT;
                `OP_MOV: alu_op = ALU_MOV;
                `OP_SAR: alu_op = ALU_SAR;
                `OP_SLR: alu_op = ALU_SLR;
                `OP_SLL: alu_op = ALU_SLL;
                `OP_INC: alu_op = ALU_INC;
                `OP_DEC: alu_op = ALU_DEC;
                default: alu_op = ALU_NOP;
            endcase
        end
    end

    assign r_write  = (alu_op != ALU_NOP) && (ir.r_form.op != `OP_CMP);
    assign is_shift = alu_op inside {ALU_SAR, ALU_SLR, ALU_SLL};

    // R-form words never match a jump since their top bits are zero
    always_comb begin
        case (ir.i_form.op)
            `OP_JE:  jump_taken = flags.zf;
            `OP_JB:  jump_taken = flags.cf;
            `OP_JA:  jump_taken = !flags.cf && !flags.zf;
            `OP_JL:  jump_taken = (flags.sf != flags.of);
            `OP_JG:  jump_taken = (flags.sf == flags.of) && !flags.zf;
            `OP_JMP: jump_taken = 1'b1;
            default: jump_taken = 1'b0;
        endcase
    end

    assign rf.rd_idx1 = is_r ? ir.r_form.rd : ir.i_form.rd;  // SM reads its register here
    assign rf.rd_idx2 = ir.r_form.rs;
    assign alu_a      = rf.rd_data1;
    assign alu_b      = is_shift ? `CPU_DATA_W'(ir.r_form.rs) : rf.rd_data2;

    always_comb begin
        rf.wr_en   = 1'b0;
        rf.wr_idx  = ir.i_form.rd;
        rf.wr_data = ir.i_form.imm;
        if (state == EXECUTE) begin
            if (r_write) begin
                rf.wr_en   = 1'b1;
                rf.wr_idx  = ir.r_form.rd;
                rf.wr_data = alu_result;
            end else if (is_li) begin
                rf.wr_en = 1'b1;
            end
        end else if (state == DATA && is_lm && dbus_ack) begin
            rf.wr_en   = 1'b1;           // Load lands on the ack edge
            rf.wr_data = dbus_rdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= FETCH;
            ir       <= '0;
            pc       <= '0;
            flags    <= '0;
            ibus_req <= 1'b0;
            dbus_req <= 1'b0;
            dbus_wr  <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!ibus_req) begin
                        ibus_req <= 1'b1;                // First fetch after reset
                    end else if (ibus_ack) begin
                        ir       <= ibus_rdata;
                        ibus_req <= 1'b0;
                        state    <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    flags <= alu_flags;                  // Passes through for non-ALU ops
                    pc    <= jump_taken ? ir.i_form.imm : pc + 1'b1;
                    if (is_lm || is_sm) begin
                        dbus_req <= 1'b1;
                        dbus_wr  <= is_sm;
                        state    <= DATA;
                    end else begin
                        ibus_req <= 1'b1;
                        state    <= FETCH;
                    end
                end
                DATA: begin
                    if (dbus_ack) begin
                        dbus_req <= 1'b0;
                        dbus_wr  <= 1'b0;
                        ibus_req <= 1'b1;
                        state    <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    assign ibus_cyc   = ibus_req;
    assign ibus_stb   = ibus_req;
    assign ibus_adr   = pc;              // Only moves at the end of EXECUTE
    assign dbus_cyc   = dbus_req;
    assign dbus_stb   = dbus_req;
    assign dbus_we    = dbus_wr;
    assign dbus_adr   = ir.i_form.imm;
    assign dbus_wdata = rf.rd_data1;

    a_ibus_hold: assert property (
        @(posedge clk) disable iff (reset)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr)
    ) else $error("cpu_control: ibus request changed before ack");

    a_dbus_hold: assert property (
        @(posedge clk) disable iff (reset)
        dbus_stb && !dbus_ack |=> dbus_stb && $stable(dbus_adr) && $stable(dbus_we)
            && $stable(dbus_wdata)
    ) else $error("cpu_control: dbus request changed before ack");

    a_one_bus: assert property (
        @(posedge clk) disable iff (reset)
        !(ibus_cyc && dbus_cyc)
    ) else $error("cpu_control: both buses active");

endmodule

// ==== cpu.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [`CPU_ADDR_W-1:0]  ibus_adr,
    input  logic [`CPU_INSTR_W-1:0] ibus_rdata,
    input  logic                    ibus_ack,
    output logic                    dbus_cyc,
    output logic                    dbus_stb,
    output logic                    dbus_we,
    output logic [`CPU_ADDR_W-1:0]  dbus_adr,
    output logic [`CPU_DATA_W-1:0]  dbus_wdata,
    input  logic [`CPU_DATA_W-1:0]  dbus_rdata,
    input  logic                    dbus_ack
);

    alu_op_t                alu_op;
    logic [`CPU_DATA_W-1:0] alu_a;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_result;
    flags_t                 alu_flags;
    flags_t                 flags;       // Flag register, fed back to the ALU

    reg_file_if rf ();

    register_bank bank_i (
        .clk   (clk),
        .reset (reset),
        .rf    (rf.bank)
    );

    alu alu_i (
        .op        (alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    cpu_control control_i (
        .clk        (clk),
        .reset      (reset),
        .rf         (rf.ctrl),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .flags      (flags),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack)
    );

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/100ps
`include "cpu_settings.svh"

module tb_cpu import cpu_pkg::*; ();

    localparam logic [5:0] r_ops [14] = '{`OP_NOP, `OP_ADD, `OP_AND, `OP_SUB, `OP_OR,
        `OP_XOR, `OP_MOV, `OP_NOT, `OP_SAR, `OP_SLR, `OP_SLL, `OP_INC, `OP_DEC, `OP_CMP};
    localparam logic [4:0] jump_ops [6] = '{`OP_JE, `OP_JB, `OP_JA, `OP_JL, `OP_JG, `OP_JMP};

    logic                    clk;
    logic                    reset;
    logic                    ibus_cyc;
    logic                    ibus_stb;
    logic [`CPU_ADDR_W-1:0]  ibus_adr;
    logic [`CPU_INSTR_W-1:0] ibus_rdata;
    logic                    ibus_ack;
    logic                    dbus_cyc;
    logic                    dbus_stb;
    logic                    dbus_we;
    logic [`CPU_ADDR_W-1:0]  dbus_adr;
    logic [`CPU_DATA_W-1:0]  dbus_wdata;
    logic [`CPU_DATA_W-1:0]  dbus_rdata;
    logic                    dbus_ack;

    logic [`CPU_INSTR_W-1:0] imem [256];     // Instruction memory model
    logic [`CPU_DATA_W-1:0]  dmem [256];     // Data memory shared with the reference model
    logic [`CPU_DATA_W-1:0]  model_regs [8];
    logic [`CPU_ADDR_W-1:0]  model_pc;
    flags_t                  model_flags;
    int                      seed;

    cpu cpu_i (
        .clk        (clk),
        .reset      (reset),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_rdata (ibus_rdata),
        .ibus_ack   (ibus_ack),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_wdata (dbus_wdata),
        .dbus_rdata (dbus_rdata),
        .dbus_ack   (dbus_ack)
    );

    always #5 clk = ~clk;

    task automatic next_cycle;
        @(posedge clk);
        #1;                                  // Drive and sample just after the edge
    endtask

    task automatic abort_run;
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0s expected %h got %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR: %0s", what);
            abort_run();
        end
    endtask

    task automatic check_bus_rules;
        check_true(!ibus_stb || ibus_cyc, "ibus_stb is high without ibus_cyc");
        check_true(!dbus_stb || dbus_cyc, "dbus_stb is high without dbus_cyc");
        check_true(!(ibus_cyc && dbus_cyc), "both buses are active at the same time");
    endtask

    // Weighted mix of ALU ops, LI, LM, SM and jumps with random targets
    task automatic fill_memories;
        int          kind;
        logic [15:0] w;
        for (int i = 0; i < 256; i++) begin
            kind = {$random(seed)} % 16;
            w    = 16'($random(seed));
            if (kind < 7) begin
                w = {4'b0000, r_ops[{$random(seed)} % 14], w[5:0]};
            end else if (kind < 10) begin
                w = {`OP_LI, w[10:0]};
            end else if (kind == 10) begin
                w = {`OP_LM, w[10:0]};
            end else if (kind < 13) begin
                w = {`OP_SM, w[10:0]};
            end else begin
                w = {jump_ops[{$random(seed)} % 6], w[10:0]};
            end
            imem[i] = w;
            dmem[i] = 8'($random(seed));
        end
    endtask

    task automatic wait_request(input logic data_bus);
        int    cycles;
        string which;
        cycles = 0;
        if (data_bus) begin
            which = "data bus";
        end else begin
            which = "instruction bus";
        end
        while (!(data_bus ? dbus_stb : ibus_stb)) begin
            check_true(cycles < 50, {which, " request did not arrive within 50 cycles"});
            check_true(data_bus || !dbus_cyc, "data bus used by a non-memory instruction");
            check_bus_rules();
            next_cycle();
            cycles++;
        end
        check_bus_rules();
    endtask

    task automatic serve_fetch(output logic [15:0] word);
        logic [7:0] adr;
        int         delay;
        adr = ibus_adr;
        check_equal("ibus_adr", model_pc, adr);
        delay = {$random(seed)} % 4;
        repeat (delay) begin                 // Back-pressure holds the request
            next_cycle();
            check_bus_rules();
            check_true(ibus_stb, "ibus_stb fell before ack");
            check_equal("ibus_adr", adr, ibus_adr);
        end
        word       = imem[adr];
        ibus_rdata = word;
        ibus_ack   = 1'b1;
        next_cycle();
        ibus_ack   = 1'b0;
        ibus_rdata = 16'($random(seed));
        check_true(!ibus_stb, "ibus_stb still high the cycle after ack");
    endtask

    task automatic serve_data(input logic store, input logic [7:0] adr, input logic [7:0] data);
        int delay;
        check_equal("dbus_we", store, dbus_we);
        check_equal("dbus_adr", adr, dbus_adr);
        if (store) begin
            check_equal("dbus_wdata", data, dbus_wdata);
        end
        delay = {$random(seed)} % 4;
        repeat (delay) begin
            next_cycle();
            check_bus_rules();
            check_true(dbus_stb, "dbus_stb fell before ack");
            check_equal("dbus_we", store, dbus_we);
            check_equal("dbus_adr", adr, dbus_adr);
        end
        dbus_rdata = dmem[adr];
        dbus_ack   = 1'b1;
        next_cycle();
        dbus_ack   = 1'b0;
        dbus_rdata = 8'($random(seed));
        check_true(!dbus_stb, "dbus_stb still high the cycle after ack");
        if (store) begin
            dmem[adr] = data;
        end
    endtask

    // Reference model of one instruction that returns mem_kind 1 for a load and 2 for a store
    task automatic execute_model(input logic [15:0] w, output int mem_kind,
                                 output logic [7:0] mem_adr, output logic [7:0] mem_data);
        logic [2:0] rd;
        logic [2:0] rs;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] r;
        logic [8:0] wide;
        logic       cf;
        logic       of;
        logic       wr;
        logic       upd;
        logic       taken;
        rd       = w[5:3];
        rs       = w[2:0];
        a        = model_regs[rd];
        b        = model_regs[rs];
        taken    = 1'b0;
        mem_kind = 0;
        mem_adr  = w[7:0];
        mem_data = model_regs[w[10:8]];
        if (w[15:12] == 4'b0000) begin
            r   = a;
            cf  = 1'b0;
            of  = 1'b0;
            wr  = 1'b1;
            upd = 1'b1;
            case (w[11:6])
                `OP_ADD: begin
                    wide = a + b;
                    r    = wide[7:0];
                    cf   = wide[8];
                    of   = (a[7] == b[7]) && (r[7] != a[7]);
                end
                `OP_SUB, `OP_CMP: begin
                    r  = a - b;
                    cf = (a < b);            // Unsigned borrow
                    of = (a[7] != b[7]) && (r[7] != a[7]);
                    wr = (w[11:6] == `OP_SUB);
                end
                `OP_AND: r = a & b;
                `OP_OR:  r = a | b;
                `OP_XOR: r = a ^ b;
                `OP_NOT: r = ~a;
                `OP_MOV: r = b;
                `OP_SAR: begin
                    r  = $signed(a) >>> rs;
                    cf = (rs != 0) && a[rs - 1];
                end
                `OP_SLR: begin
                    r  = a >> rs;
                    cf = (rs != 0) && a[rs - 1];
                end
                `OP_SLL: begin
                    r  = a << rs;
                    cf = (rs != 0) && a[8 - rs];
                end
                `OP_INC: begin
                    r  = a + 8'd1;
                    cf = (r == 8'h00);
                    of = (r == 8'h80);
                end
                `OP_DEC: begin
                    r  = a - 8'd1;
                    cf = (a == 8'h00);
                    of = (r == 8'h7f);
                end
                default: begin               // NOP and unlisted codes change nothing
                    wr  = 1'b0;
                    upd = 1'b0;
                end
            endcase
            if (upd) begin
                model_flags = {r == 8'h00, r[7], cf, of};
            end
            if (wr) begin
                model_regs[rd] = r;
            end
        end else begin
            case (w[15:11])
                `OP_LI:  model_regs[w[10:8]] = w[7:0];
                `OP_LM: begin
                    model_regs[w[10:8]] = dmem[w[7:0]];
                    mem_kind            = 1;
                end
                `OP_SM:  mem_kind = 2;
                `OP_JE:  taken = model_flags.zf;
                `OP_JB:  taken = model_flags.cf;
                `OP_JA:  taken = !model_flags.cf && !model_flags.zf;
                `OP_JL:  taken = (model_flags.sf != model_flags.of);
                `OP_JG:  taken = (model_flags.sf == model_flags.of) && !model_flags.zf;
                `OP_JMP: taken = 1'b1;
                default: taken = 1'b0;
            endcase
        end
        model_pc = taken ? w[7:0] : model_pc + 8'd1;
    endtask

    initial begin
        logic [15:0] word;
        int          kind;
        logic [7:0]  adr;
        logic [7:0]  data;
        clk         = 1'b0;
        reset       = 1'b1;
        ibus_rdata  = '0;
        ibus_ack    = 1'b0;
        dbus_rdata  = '0;
        dbus_ack    = 1'b0;
        seed        = 27736;
        model_pc    = '0;
        model_flags = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        fill_memories();
        repeat (5) begin
            next_cycle();
            check_true(!ibus_cyc && !ibus_stb && !dbus_cyc && !dbus_stb && !dbus_we,
                       "a bus is active while reset is asserted");
        end
        reset = 1'b0;
        for (int n = 0; n < 400; n++) begin
            wait_request(1'b0);
            serve_fetch(word);
            execute_model(word, kind, adr, data);
            if (kind != 0) begin
                wait_request(1'b1);
                serve_data(kind == 2, adr, data);
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
cpu_pkg.sv
reg_file_if.sv
register_bank.sv
alu.sv
cpu_control.sv
cpu.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu8

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - reg_file_if.sv
  - register_bank.sv
  - alu.sv
  - cpu_control.sv
  - cpu.sv
  - target: simulation
    files:
      - tb_cpu.sv
